// ==== sim.f ====
verilog/line_bus_pkg.sv
verilog/line_fill.sv
verilog/line_drain.sv
verilog/burst_ctrl.sv
verilog/line_bus_bridge.sv
testbench/burst_mem_model.sv
testbench/line_bus_checker.sv
testbench/tb_line_bus_bridge.sv

// ==== Makefile ====
.PHONY: sim clean

# A crash or a stopped assertion also ends up as a failure in the log.
sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_line_bus_bridge -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
	cat sim.log
	! grep -q -F "*** FAILED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_line_bus_bridge.sv ====
`timescale 1ns/1ps

module tb_line_bus_bridge;

    localparam int RESP_TIMEOUT = 200;          // Cycles allowed for one request.
    localparam int SETTLE       = 12;           // Cycles watched for an extra response.

    logic                clk;
    logic                rst;
    line_bus_pkg::addr_t dfp_addr;
    logic                dfp_read;
    logic                dfp_write;
    line_bus_pkg::line_t dfp_wdata;
    line_bus_pkg::line_t dfp_rdata;
    logic                dfp_resp;
    line_bus_pkg::addr_t bmem_addr;
    logic                bmem_read;
    logic                bmem_write;
    line_bus_pkg::beat_t bmem_wdata;
    logic                bmem_ready;
    line_bus_pkg::addr_t bmem_raddr;
    line_bus_pkg::beat_t bmem_rdata;
    logic                bmem_rvalid;
    logic                stall_en;
    logic                gap_en;

    int                  seed = 32'hf612;
    int                  checks;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    line_bus_pkg::addr_t stress_addr [4];
    line_bus_pkg::line_t stress_line [4];
    line_bus_pkg::line_t first_line;            // Written in the write-then-read test.

    line_bus_bridge i_line_bus_bridge (
        .clk         (clk),
        .rst         (rst),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_write   (dfp_write),
        .dfp_wdata   (dfp_wdata),
        .dfp_rdata   (dfp_rdata),
        .dfp_resp    (dfp_resp),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    burst_mem_model i_burst_mem_model (
        .clk         (clk),
        .rst         (rst),
        .stall_en    (stall_en),
        .gap_en      (gap_en),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic line_bus_pkg::addr_t align(input line_bus_pkg::addr_t a);
        return a & ~32'h1f;                     // A line covers 32 bytes.
    endfunction

    // Line as it sits in the memory model with beat 0 at the lowest address.
    function automatic line_bus_pkg::line_t peek_line(input line_bus_pkg::addr_t a);
        line_bus_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*64 +: 64] = i_burst_mem_model.read_beat(a + 32'(i * 8));
        end
        return l;
    endfunction

    task automatic compare(input string test, input string what,
                           input logic [255:0] expected, input logic [255:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic finish_test(input string test, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", test);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", test, errors - errors_before);
        end
    endtask

    task automatic random_line(output line_bus_pkg::line_t l);
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
    endtask

    // One-cycle request strobe; the DUT samples it on the second edge.
    task automatic strobe(input logic is_write, input line_bus_pkg::addr_t addr,
                          input line_bus_pkg::line_t data);
        @(posedge clk);
        dfp_addr  <= addr;
        dfp_wdata <= data;
        dfp_read  <= !is_write;
        dfp_write <= is_write;
        @(posedge clk);
        dfp_read  <= 1'b0;
        dfp_write <= 1'b0;
    endtask

    task automatic wait_resp(input string test, output int resp_count,
                             output line_bus_pkg::addr_t cmd_addr);
        int   cycles;
        logic seen;
        logic cmd_seen;
        cycles     = 0;
        seen       = 1'b0;
        cmd_seen   = 1'b0;
        resp_count = 0;
        cmd_addr   = '0;
        while (!seen && cycles < RESP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if ((bmem_read || bmem_write) && !cmd_seen) begin
                cmd_seen = 1'b1;
                cmd_addr = bmem_addr;
            end
            seen = dfp_resp;
        end
        if (!seen) begin
            errors++;
            $display("Test %s hung: no dfp_resp within %0d cycles.", test, RESP_TIMEOUT);
        end else begin
            resp_count = 1;
            repeat (SETTLE) begin
                @(negedge clk);
                if (dfp_resp) begin
                    resp_count++;
                end
            end
        end
    endtask

    task automatic write_line(input string test, input line_bus_pkg::addr_t addr,
                              input line_bus_pkg::line_t data);
        int                  resp_count;
        line_bus_pkg::addr_t cmd_addr;
        strobe(1'b1, addr, data);
        wait_resp(test, resp_count, cmd_addr);
        compare(test, "write responses", 256'(1), 256'(resp_count));
        compare(test, "write address", 256'(align(addr)), 256'(cmd_addr));
    endtask

    task automatic read_line(input string test, input line_bus_pkg::addr_t addr,
                             input line_bus_pkg::line_t expected);
        int                  resp_count;
        line_bus_pkg::addr_t cmd_addr;
        strobe(1'b0, addr, '0);
        wait_resp(test, resp_count, cmd_addr);
        compare(test, "read responses", 256'(1), 256'(resp_count));
        compare(test, "read address", 256'(align(addr)), 256'(cmd_addr));
        compare(test, "read line", expected, dfp_rdata);
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        compare("reset", "dfp_resp", 256'(0), 256'(dfp_resp));
        compare("reset", "bmem_read", 256'(0), 256'(bmem_read));
        compare("reset", "bmem_write", 256'(0), 256'(bmem_write));
        compare("reset", "dfp_rdata", 256'(0), dfp_rdata);
        finish_test("reset", err0);
    endtask

    task automatic write_then_read();
        int err0;
        err0 = errors;
        first_line = {64'h4444_4444_dddd_0003, 64'h3333_3333_cccc_0002,
                      64'h2222_2222_bbbb_0001, 64'h1111_1111_aaaa_0000};
        write_line("write_read", 32'h0000_1000, first_line);
        compare("write_read", "memory beat 0", 256'(64'h1111_1111_aaaa_0000),
                256'(i_burst_mem_model.read_beat(32'h0000_1000)));
        compare("write_read", "memory beat 3", 256'(64'h4444_4444_dddd_0003),
                256'(i_burst_mem_model.read_beat(32'h0000_1018)));
        read_line("write_read", 32'h0000_1000, first_line);
        finish_test("write_read", err0);
    endtask

    task automatic unaligned_access();
        int                  err0;
        line_bus_pkg::line_t l0;
        line_bus_pkg::line_t l1;
        err0 = errors;
        random_line(l0);
        random_line(l1);
        write_line("alignment", 32'h0000_2040, l0);
        read_line("alignment", 32'h0000_2053, l0);
        write_line("alignment", 32'h0000_2075, l1);    // Lands on the line at 0x2060.
        read_line("alignment", 32'h0000_2060, l1);
        finish_test("alignment", err0);
    endtask

    task automatic stalled_writes();
        int err0;
        err0 = errors;
        @(posedge clk);
        stall_en <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            stress_addr[i] = 32'h0000_3000 + 32'(i) * 32'h0000_0460;
            random_line(stress_line[i]);
            write_line("write_stalls", stress_addr[i], stress_line[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_line("write_stalls", stress_addr[i], stress_line[i]);
        end
        @(posedge clk);
        stall_en <= 1'b0;
        finish_test("write_stalls", err0);
    endtask

    task automatic gapped_reads();
        int err0;
        err0 = errors;
        @(posedge clk);
        gap_en <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            read_line("read_gaps", stress_addr[i], stress_line[i]);
        end
        read_line("read_gaps", 32'h0000_1000, first_line);
        @(posedge clk);
        gap_en <= 1'b0;
        finish_test("read_gaps", err0);
    endtask

    task automatic busy_strobe_dropped();
        int                  err0;
        int                  resp_count;
        line_bus_pkg::addr_t cmd_addr;
        line_bus_pkg::line_t l0;
        line_bus_pkg::line_t l1;
        err0 = errors;
        random_line(l0);
        random_line(l1);
        strobe(1'b1, 32'h0000_4000, l0);
        strobe(1'b1, 32'h0000_4000, l1);              // Sent during the first burst.
        wait_resp("busy_strobe", resp_count, cmd_addr);
        compare("busy_strobe", "responses", 256'(1), 256'(resp_count));
        compare("busy_strobe", "memory line", l0, peek_line(32'h0000_4000));
        read_line("busy_strobe", 32'h0000_4000, l0);
        finish_test("busy_strobe", err0);
    endtask

    initial begin
        rst          = 1'b1;
        dfp_addr     = '0;
        dfp_read     = 1'b0;
        dfp_write    = 1'b0;
        dfp_wdata    = '0;
        stall_en     = 1'b0;
        gap_en       = 1'b0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        write_then_read();
        unaligned_access();
        stalled_writes();
        gapped_reads();
        busy_strobe_dropped();
        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/line_bus_checker.sv ====
`timescale 1ns/1ps

module line_bus_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      bmem_read,
    input logic                      bmem_write,
    input line_bus_pkg::addr_t       bmem_addr,
    input logic                      dfp_resp,
    input line_bus_pkg::ctrl_state_t state
);

    commands_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && bmem_write))
        else $error("bmem_read and bmem_write are high in the same cycle.");

    command_aligned: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) |-> (bmem_addr[line_bus_pkg::LINE_OFFSET_BITS-1:0] == '0))
        else $error("bmem_addr is not line aligned during a command.");

    resp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        dfp_resp |=> !dfp_resp)
        else $error("dfp_resp stayed high for two cycles.");

    resp_after_busy: assert property (@(posedge clk) disable iff (rst)
        dfp_resp |-> ($past(state) != line_bus_pkg::idle))
        else $error("dfp_resp followed an idle cycle.");

endmodule

bind line_bus_bridge line_bus_checker i_line_bus_checker (
    .clk        (clk),
    .rst        (rst),
    .bmem_read  (bmem_read),
    .bmem_write (bmem_write),
    .bmem_addr  (bmem_addr),
    .dfp_resp   (dfp_resp),
    .state      (i_burst_ctrl.state)
);

// ==== testbench/burst_mem_model.sv ====
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                clk,
    input  logic                rst,

    input  logic                stall_en,       // Random ready stalls when high.
    input  logic                gap_en,         // Random gaps between read beats when high.

    input  line_bus_pkg::addr_t bmem_addr,
    input  logic                bmem_read,
    input  logic                bmem_write,
    input  line_bus_pkg::beat_t bmem_wdata,
    output logic                bmem_ready,
    output line_bus_pkg::addr_t bmem_raddr,
    output line_bus_pkg::beat_t bmem_rdata,
    output logic                bmem_rvalid
);

    line_bus_pkg::beat_t     mem [line_bus_pkg::addr_t];
    int                      seed = 32'hf612;
    line_bus_pkg::beat_idx_t wr_idx;
    line_bus_pkg::beat_idx_t rd_idx;
    line_bus_pkg::addr_t     rd_base;
    logic                    rd_active;

    // Byte address of one beat inside a burst.
    function automatic line_bus_pkg::addr_t beat_addr(input line_bus_pkg::addr_t base,
                                                      input line_bus_pkg::beat_idx_t idx);
        return base + {27'b0, idx, 3'b000};
    endfunction

    function automatic line_bus_pkg::beat_t read_beat(input line_bus_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a, a};                         // Unwritten beats carry their own address.
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            bmem_ready  <= 1'b0;
            bmem_raddr  <= '0;
            bmem_rdata  <= '0;
            bmem_rvalid <= 1'b0;
            wr_idx      <= '0;
            rd_idx      <= '0;
            rd_base     <= '0;
            rd_active   <= 1'b0;
        end else begin
            bmem_ready  <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
            bmem_rvalid <= 1'b0;
            if (bmem_write && bmem_ready) begin
                mem[beat_addr(bmem_addr, wr_idx)] = bmem_wdata;
                wr_idx <= wr_idx + 2'd1;
            end
            if (bmem_read && bmem_ready && !rd_active) begin
                rd_base   <= bmem_addr;         // Burst starts on the next cycle.
                rd_idx    <= '0;
                rd_active <= 1'b1;
            end
            if (rd_active && !(gap_en && (($random(seed) & 1) != 0))) begin
                bmem_rvalid <= 1'b1;
                bmem_rdata  <= read_beat(beat_addr(rd_base, rd_idx));
                bmem_raddr  <= rd_base;
                rd_idx      <= rd_idx + 2'd1;
                if (rd_idx == 2'd3) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== verilog/line_bus_bridge.sv ====
`timescale 1ns/1ps

module line_bus_bridge (
    input  logic                clk,
    input  logic                rst,

    // Cache side.
    input  line_bus_pkg::addr_t dfp_addr,
    input  logic                dfp_read,
    input  logic                dfp_write,
    input  line_bus_pkg::line_t dfp_wdata,
    output line_bus_pkg::line_t dfp_rdata,
    output logic                dfp_resp,

    // Memory side.
    output line_bus_pkg::addr_t bmem_addr,
    output logic                bmem_read,
    output logic                bmem_write,
    output line_bus_pkg::beat_t bmem_wdata,
    input  logic                bmem_ready,
    input  line_bus_pkg::addr_t bmem_raddr,     // The bridge ignores the echoed burst address.
    input  line_bus_pkg::beat_t bmem_rdata,
    input  logic                bmem_rvalid
);

    logic fill_start;
    logic fill_done;
    logic drain_load;
    logic drain_advance;
    logic drain_done;

    burst_ctrl i_burst_ctrl (
        .clk           (clk),
        .rst           (rst),
        .dfp_addr      (dfp_addr),
        .dfp_read      (dfp_read),
        .dfp_write     (dfp_write),
        .bmem_ready    (bmem_ready),
        .fill_done     (fill_done),
        .drain_done    (drain_done),
        .bmem_addr     (bmem_addr),
        .bmem_read     (bmem_read),
        .bmem_write    (bmem_write),
        .fill_start    (fill_start),
        .drain_load    (drain_load),
        .drain_advance (drain_advance),
        .dfp_resp      (dfp_resp)
    );

    line_fill i_line_fill (
        .clk         (clk),
        .rst         (rst),
        .fill_start  (fill_start),
        .bmem_rvalid (bmem_rvalid),
        .bmem_rdata  (bmem_rdata),
        .fill_line   (dfp_rdata),
        .fill_done   (fill_done)
    );

    line_drain i_line_drain (
        .clk           (clk),
        .rst           (rst),
        .drain_load    (drain_load),
        .dfp_wdata     (dfp_wdata),
        .drain_advance (drain_advance),
        .drain_beat    (bmem_wdata),
        .drain_done    (drain_done)
    );

endmodule

// ==== verilog/burst_ctrl.sv ====
`timescale 1ns/1ps

module burst_ctrl (
    input  logic                clk,
    input  logic                rst,

    input  line_bus_pkg::addr_t dfp_addr,
    input  logic                dfp_read,
    input  logic                dfp_write,
    input  logic                bmem_ready,
    input  logic                fill_done,
    input  logic                drain_done,

    output line_bus_pkg::addr_t bmem_addr,
    output logic                bmem_read,
    output logic                bmem_write,
    output logic                fill_start,
    output logic                drain_load,
    output logic                drain_advance,
    output logic                dfp_resp
);

    line_bus_pkg::ctrl_state_t state;
    line_bus_pkg::ctrl_state_t state_next;
    line_bus_pkg::addr_t       aligned_addr;
    logic                      read_req;
    logic                      write_req;
    logic                      done;

    // Strobes count only in idle; anything else is dropped. Read wins a tie.
    assign read_req  = (state == line_bus_pkg::idle) && dfp_read;
    assign write_req = (state == line_bus_pkg::idle) && dfp_write && !dfp_read;

    assign aligned_addr = {dfp_addr[line_bus_pkg::ADDR_BITS-1:line_bus_pkg::LINE_OFFSET_BITS],
                           {line_bus_pkg::LINE_OFFSET_BITS{1'b0}}};

    assign fill_start = read_req;
    assign drain_load = write_req;

    // Commands follow the state, so they rise the cycle after the strobe.
    assign bmem_read     = (state == line_bus_pkg::read_cmd);
    assign bmem_write    = (state == line_bus_pkg::write_burst);
    assign drain_advance = bmem_write && bmem_ready;

    // Either path finishing in its own state.
    assign done = ((state == line_bus_pkg::read_wait) && fill_done) ||
                  ((state == line_bus_pkg::write_burst) && drain_done);

    always_comb begin
        state_next = state;
        case (state)
            line_bus_pkg::idle: begin
                if (read_req) begin
                    state_next = line_bus_pkg::read_cmd;
                end else if (write_req) begin
                    state_next = line_bus_pkg::write_burst;
                end
            end
            line_bus_pkg::read_cmd: begin
                if (bmem_ready) begin
                    state_next = line_bus_pkg::read_wait;   // Command taken.
                end
            end
            line_bus_pkg::read_wait: begin
                if (fill_done) begin
                    state_next = line_bus_pkg::idle;
                end
            end
            line_bus_pkg::write_burst: begin
                if (drain_done) begin
                    state_next = line_bus_pkg::idle;
                end
            end
            default: begin
                state_next = line_bus_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= line_bus_pkg::idle;
            bmem_addr <= '0;
            dfp_resp  <= 1'b0;
        end else begin
            state    <= state_next;
            dfp_resp <= done;                   // One cycle after the last beat.
            if (read_req || write_req) begin
                bmem_addr <= aligned_addr;      // Held for the whole burst.
            end
        end
    end

endmodule

// ==== verilog/line_drain.sv ====
`timescale 1ns/1ps

module line_drain (
    input  logic                clk,
    input  logic                rst,

    input  logic                drain_load,
    input  line_bus_pkg::line_t dfp_wdata,
    input  logic                drain_advance,

    output line_bus_pkg::beat_t drain_beat,
    output logic                drain_done
);

    line_bus_pkg::line_t     line_q;
    line_bus_pkg::beat_idx_t beat_idx;
    logic                    last_beat;

    assign last_beat = (beat_idx == line_bus_pkg::beat_idx_t'(line_bus_pkg::BEATS_PER_LINE - 1));

    // Current beat on the memory bus.
    assign drain_beat = line_q[beat_idx*line_bus_pkg::BEAT_BITS +: line_bus_pkg::BEAT_BITS];

    // Acceptance of the last beat ends the burst.
    assign drain_done = drain_advance && last_beat;

    always_ff @(posedge clk) begin
        if (drain_load) begin
            line_q <= dfp_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_idx <= '0;
        end else if (drain_load) begin
            beat_idx <= '0;
        end else if (drain_advance) begin
            beat_idx <= beat_idx + 1'b1;    // Back to zero after the fourth beat.
        end
    end

endmodule

// ==== verilog/line_fill.sv ====
`timescale 1ns/1ps

module line_fill (
    input  logic                clk,
    input  logic                rst,

    input  logic                fill_start,
    input  logic                bmem_rvalid,
    input  line_bus_pkg::beat_t bmem_rdata,

    output line_bus_pkg::line_t fill_line,
    output logic                fill_done
);

    line_bus_pkg::beat_idx_t beat_cnt;
    line_bus_pkg::line_t     accum;
    logic                    last_beat;

    assign last_beat = (beat_cnt == line_bus_pkg::beat_idx_t'(line_bus_pkg::BEATS_PER_LINE - 1));

    // The line is complete in the cycle of its fourth beat.
    assign fill_done = bmem_rvalid && last_beat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (fill_start) begin
            beat_cnt <= '0;                 // Drops any stray beat count.
        end else if (bmem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;    // Wraps to zero after the last beat.
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_rvalid) begin
            accum[beat_cnt*line_bus_pkg::BEAT_BITS +: line_bus_pkg::BEAT_BITS] <= bmem_rdata;
        end
    end

    // The finished line stays on fill_line until the next one completes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_line <= '0;
        end else if (fill_done) begin
            fill_line <= {bmem_rdata,
                          accum[line_bus_pkg::LINE_BITS-line_bus_pkg::BEAT_BITS-1:0]};
        end
    end

endmodule

// ==== verilog/line_bus_pkg.sv ====
package line_bus_pkg;

    // Burst geometry.
    localparam int BEAT_BITS        = 64;                          // Bits in one memory beat.
    localparam int LINE_BITS        = 256;                         // Bits in one cache line.
    localparam int BEATS_PER_LINE   = LINE_BITS / BEAT_BITS;       // Four beats per burst.
    localparam int BEAT_IDX_BITS    = $clog2(BEATS_PER_LINE);
    localparam int ADDR_BITS        = 32;
    localparam int LINE_OFFSET_BITS = 5;                           // A line spans 32 bytes.

    // One memory beat.
    typedef logic [BEAT_BITS-1:0] beat_t;

    // One cache line, beat 0 in the lowest bits.
    typedef logic [LINE_BITS-1:0] line_t;

    // Byte address on both sides of the bridge.
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Position of a beat inside its line.
    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

    // Request controller states.
    typedef enum logic [1:0] {
        idle,        // Waiting for a cache strobe.
        read_cmd,    // Read command held until the memory takes it.
        read_wait,   // Collecting the returning beats.
        write_burst  // Sending the four write beats.
    } ctrl_state_t;

endpackage
